// File: filelist.f
hw/simple_fu_pkg.sv
hw/simple_alu.sv
hw/simple_issue_select.sv
hw/simple_wb_port.sv
hw/ex_simple.sv
verification/ex_simple_checker.sv
verification/tb_ex_simple.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module tb_ex_simple -o sim_ex_simple \
    && ./obj_dir/sim_ex_simple | tee sim.log \
    || { echo "Build or simulation did not run"; exit 1; }

grep -q "^TESTBENCH PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: verification/tb_ex_simple.sv
`timescale 1ns/1ns

module tb_ex_simple import simple_fu_pkg::*; ();

    typedef struct packed {
        logic [127:0]         name;
        logic [entry_w-1:0]   e0;
        logic [entry_w-1:0]   e1;
        logic [rob_num_w-1:0] n0;
        logic [rob_num_w-1:0] n1;
        logic                 sel;
        logic [1:0]           dly;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic [entry_w-1:0]    rs_simple_0;
    logic [entry_w-1:0]    rs_simple_1;
    logic [rob_num_w-1:0]  rs_simple_0_entry_num;
    logic [rob_num_w-1:0]  rs_simple_1_entry_num;
    logic                  selector;
    logic                  simple_0_issue;
    logic                  simple_1_issue;
    logic [exec_w-1:0]     executed_inst;
    logic [rob_num_w-1:0]  simple_rob_num;
    logic                  rob_req;
    logic                  rob_ack;
    logic [xlen-1:0]       write_data;
    logic [reg_addr_w-1:0] write_addr;
    logic                  write_en;
    logic [127:0]          test_name;
    logic [1:0]            cur_dly;
    int                    pass_count;
    int                    fail_count;
    int                    pending;
    int                    tb_errors;
    integer                seed;
    logic [31:0]           rnd [12];
    row_t                  rows [17];

    ex_simple dut (.*);

    ex_simple_checker u_checker (.*);

    //////////////////////////////
    // Clock, ack responder, watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ack after the row's delay, drop once req falls
    initial begin : ack_responder
        int cnt;
        cnt = 0;
        rob_ack = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            if (rob_req && !rob_ack) begin
                if (cnt >= int'(cur_dly)) begin
                    rob_ack = 1'b1;
                    cnt = 0;
                end else begin
                    cnt++;
                end
            end else if (!rob_req && rob_ack) begin
                rob_ack = 1'b0;
            end
        end
    end

    // Rows times (max delay + 8) cycles, plus reset
    initial begin
        #(($size(rows) * (3 + 8) + 3) * 100);
        $display("Watchdog: the run did not finish in its time limit");
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////
    // Table helpers
    //////////////////////////////

    // Valid bits as {s2, s1}
    function automatic logic [entry_w-1:0] ent(logic [4:0] op, logic [31:0] a, logic [31:0] b,
                                               logic [1:0] v, logic rw, logic [4:0] rd);
        logic [entry_w-1:0] e;
        e = '0;
        e[aluop_lsb +: aluop_w]  = op;
        e[regwrite_bit]          = rw;
        e[s2_lsb +: xlen]        = b;
        e[s2_valid_bit]          = v[1];
        e[s1_lsb +: xlen]        = a;
        e[s1_valid_bit]          = v[0];
        e[rd_lsb +: reg_addr_w]  = rd;
        return e;
    endfunction

    function automatic int is_ready(logic [entry_w-1:0] e);
        return (e[s1_valid_bit] && e[s2_valid_bit]) ? 1 : 0;
    endfunction

    task automatic set_row(input int i, input logic [127:0] name, input logic [entry_w-1:0] e0,
                           input logic [entry_w-1:0] e1, input logic [3:0] n0,
                           input logic [3:0] n1, input logic sel, input logic [1:0] dly);
        rows[i] = '{name, e0, e1, n0, n1, sel, dly};
    endtask

    //////////////////////////////
    // Row driver
    //////////////////////////////

    // Entered 5 ns after a rising edge
    task automatic run_row(input int i);
        int  want;
        int  got;
        int  waited;
        logic seen_req;
        logic done;
        logic iss0;
        logic iss1;
        rs_simple_0           = rows[i].e0;
        rs_simple_1           = rows[i].e1;
        rs_simple_0_entry_num = rows[i].n0;
        rs_simple_1_entry_num = rows[i].n1;
        selector              = rows[i].sel;
        test_name             = rows[i].name;
        cur_dly               = rows[i].dly;
        want   = is_ready(rows[i].e0) + is_ready(rows[i].e1);
        got    = 0;
        waited = 0;
        while (got < want && waited < 2 * (3 + 8)) begin
            @(negedge clk);
            iss0 = simple_0_issue;
            iss1 = simple_1_issue;
            if (iss0) got++;
            if (iss1) got++;
            @(posedge clk);
            #5;
            // Issued slot retires its operands
            if (iss0) begin
                rs_simple_0[s1_valid_bit] = 1'b0;
                rs_simple_0[s2_valid_bit] = 1'b0;
            end
            if (iss1) begin
                rs_simple_1[s1_valid_bit] = 1'b0;
                rs_simple_1[s2_valid_bit] = 1'b0;
            end
            waited++;
        end
        if (got < want) begin
            $display("Row %0s: only %0d of %0d ready entries were issued",
                     rows[i].name, got, want);
            tb_errors++;
        end
        // Drain the last transfer, or watch an idle window
        waited   = 0;
        seen_req = 1'b0;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (rob_req) seen_req = 1'b1;
            waited++;
            if (want == 0) done = waited >= 6;
            else done = (seen_req && !rob_req && !rob_ack) || waited > 3 + 8;
        end
        if (want > 0 && (!seen_req || rob_req || rob_ack)) begin
            $display("Row %0s: the ROB transfer did not complete", rows[i].name);
            tb_errors++;
        end
        @(posedge clk);
        #5;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst_n                 = 1'b0;
        rs_simple_0           = '0;
        rs_simple_1           = '0;
        rs_simple_0_entry_num = '0;
        rs_simple_1_entry_num = '0;
        selector              = 1'b0;
        test_name             = "reset";
        cur_dly               = 2'd0;
        tb_errors             = 0;
        seed                  = 32'he9b3_2e36;
        for (int k = 0; k < 12; k++) rnd[k] = $random(seed);

        // One row per opcode on slot 0
        set_row(0, "add", ent(alu_add, rnd[0], rnd[1], 2'b11, 1'b1, 5'd1), '0,
                4'd0, 4'd0, 1'b0, 2'd0);
        set_row(1, "sub", ent(alu_sub, rnd[2], rnd[3], 2'b11, 1'b1, 5'd2), '0,
                4'd1, 4'd0, 1'b0, 2'd1);
        set_row(2, "and", ent(alu_and, rnd[4], rnd[5], 2'b11, 1'b1, 5'd3), '0,
                4'd2, 4'd0, 1'b0, 2'd2);
        set_row(3, "or", ent(alu_or, rnd[6], rnd[7], 2'b11, 1'b1, 5'd4), '0,
                4'd3, 4'd0, 1'b0, 2'd3);
        set_row(4, "xor", ent(alu_xor, rnd[8], rnd[9], 2'b11, 1'b0, 5'd5), '0,
                4'd4, 4'd0, 1'b0, 2'd0);
        // Shift amounts come from the low five bits only
        set_row(5, "sll", ent(alu_sll, rnd[10], 32'hffff_ffe5, 2'b11, 1'b1, 5'd6), '0,
                4'd5, 4'd0, 1'b0, 2'd1);
        set_row(6, "srl", ent(alu_srl, 32'h8000_00f0, 32'h0000_0124, 2'b11, 1'b1, 5'd7), '0,
                4'd6, 4'd0, 1'b0, 2'd2);
        set_row(7, "sra", ent(alu_sra, 32'h8000_00f0, 32'h0000_0044, 2'b11, 1'b1, 5'd8), '0,
                4'd7, 4'd0, 1'b0, 2'd3);
        set_row(8, "slt", ent(alu_slt, 32'hffff_fff0, 32'd3, 2'b11, 1'b1, 5'd9), '0,
                4'd8, 4'd0, 1'b0, 2'd0);
        set_row(9, "sltu", ent(alu_sltu, 32'hffff_fff0, 32'd3, 2'b11, 1'b1, 5'd10), '0,
                4'd9, 4'd0, 1'b0, 2'd1);
        set_row(10, "pass2", ent(alu_pass2, rnd[11], 32'h1234_5000, 2'b11, 1'b1, 5'd11), '0,
                4'd10, 4'd0, 1'b0, 2'd2);
        set_row(11, "unused_op", ent(5'd17, rnd[0], rnd[1], 2'b11, 1'b1, 5'd12), '0,
                4'd11, 4'd0, 1'b0, 2'd3);
        // Slot 1 alone, no register write
        set_row(12, "slot1_only", '0, ent(alu_add, rnd[3], rnd[6], 2'b11, 1'b0, 5'd13),
                4'd0, 4'd9, 1'b0, 2'd1);
        // Both ready, older first
        set_row(13, "both_sel0", ent(alu_sub, rnd[2], rnd[5], 2'b11, 1'b1, 5'd14),
                ent(alu_or, rnd[3], rnd[4], 2'b11, 1'b1, 5'd15), 4'd13, 4'd14, 1'b0, 2'd2);
        set_row(14, "both_sel1", ent(alu_sltu, rnd[7], rnd[8], 2'b11, 1'b1, 5'd16),
                ent(alu_sra, rnd[9], rnd[10], 2'b11, 1'b1, 5'd17), 4'd12, 4'd15, 1'b1, 2'd3);
        // Partly ready slots stay put
        set_row(15, "not_ready", ent(alu_add, rnd[1], rnd[2], 2'b01, 1'b1, 5'd18),
                ent(alu_xor, rnd[3], rnd[4], 2'b10, 1'b1, 5'd19), 4'd1, 4'd2, 1'b0, 2'd0);
        set_row(16, "one_ready", ent(alu_and, rnd[5], rnd[6], 2'b10, 1'b1, 5'd20),
                ent(alu_pass2, rnd[7], rnd[8], 2'b11, 1'b1, 5'd21), 4'd3, 4'd15, 1'b1, 2'd1);

        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
        if (simple_0_issue || simple_1_issue || rob_req || write_en) begin
            $display("Outputs were not low after reset");
            tb_errors++;
        end

        for (int i = 0; i < $size(rows); i++) run_row(i);

        repeat (2) @(posedge clk);
        if (pending != 0) begin
            $display("%0d issued entries never reached the ROB", pending);
            tb_errors++;
        end
        $display("Tests done: %0d passed, %0d failed", pass_count, fail_count + tb_errors);
        if (fail_count + tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verification/ex_simple_checker.sv
`timescale 1ns/1ns

module ex_simple_checker import simple_fu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [entry_w-1:0]    rs_simple_0,
    input  logic [entry_w-1:0]    rs_simple_1,
    input  logic [rob_num_w-1:0]  rs_simple_0_entry_num,
    input  logic [rob_num_w-1:0]  rs_simple_1_entry_num,
    input  logic                  selector,
    input  logic                  simple_0_issue,
    input  logic                  simple_1_issue,
    input  logic [exec_w-1:0]     executed_inst,
    input  logic [rob_num_w-1:0]  simple_rob_num,
    input  logic                  rob_req,
    input  logic                  rob_ack,
    input  logic [xlen-1:0]       write_data,
    input  logic [reg_addr_w-1:0] write_addr,
    input  logic                  write_en,
    input  logic [127:0]          test_name,
    output int                    pass_count,
    output int                    fail_count,
    output int                    pending
);

    logic [exec_w-1:0]    exp_q [$];
    logic [rob_num_w-1:0] num_q [$];
    logic [127:0]         name_q [$];
    logic [exec_w-1:0]    exp_val;
    logic [exec_w-1:0]    held;
    logic [rob_num_w-1:0] exp_num;
    logic [127:0]         exp_name;
    logic                 req_d;
    logic                 ack_d;
    logic                 wen_d;
    logic                 ack_seen;
    logic                 r0;
    logic                 r1;
    logic                 want_slot;
    logic                 bad;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] alu_model(logic [4:0] op, logic [31:0] a, logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            alu_add:   return a + b;
            alu_sub:   return a + ~b + 32'd1;
            alu_and:   return a & b;
            alu_or:    return a | b;
            alu_xor:   return a ^ b;
            alu_sll:   return a << s;
            alu_srl:   return a >> s;
            // Sign fill by hand
            alu_sra:   return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
            alu_slt:   return (a[31] ^ b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            alu_sltu:  return {31'b0, a < b};
            alu_pass2: return b;
            default:   return 32'h0;
        endcase
    endfunction

    // Regwrite, result, destination
    function automatic logic [exec_w-1:0] predict(logic [entry_w-1:0] e);
        return {e[regwrite_bit],
                alu_model(e[aluop_lsb +: aluop_w], e[s1_lsb +: xlen], e[s2_lsb +: xlen]),
                e[rd_lsb +: reg_addr_w]};
    endfunction

    task flag_problem(input string what);
        $display("Checker at %0t ns: %s", $time, what);
        fail_count++;
    endtask

    //////////////////////////////
    // Mid-cycle monitor
    //////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            req_d      = 1'b0;
            ack_d      = 1'b0;
            wen_d      = 1'b0;
            ack_seen   = 1'b0;
            pass_count = 0;
            fail_count = 0;
            pending    = 0;
        end else begin
            r0 = rs_simple_0[s1_valid_bit] && rs_simple_0[s2_valid_bit];
            r1 = rs_simple_1[s1_valid_bit] && rs_simple_1[s2_valid_bit];
            if (simple_0_issue && simple_1_issue) flag_problem("both slots issued in one cycle");
            if ((simple_0_issue || simple_1_issue) && (rob_req || rob_ack || exp_q.size() != 0))
                flag_problem("an entry issued while a transfer was still open");
            if (simple_0_issue || simple_1_issue) begin
                // Older slot wins a tie, selector marks the newer one
                want_slot = (r0 && r1) ? !selector : r1;
                if (!r0 && !r1) begin
                    flag_problem("a slot issued without both operands ready");
                end else if (simple_1_issue != want_slot) begin
                    $display("[ERROR] %0s issued slot expected %0d actual %0d",
                             test_name, want_slot, simple_1_issue);
                    fail_count++;
                end
                exp_q.push_back(predict(simple_1_issue ? rs_simple_1 : rs_simple_0));
                num_q.push_back(simple_1_issue ? rs_simple_1_entry_num : rs_simple_0_entry_num);
                name_q.push_back(test_name);
            end

            // First request cycle carries the result
            if (rob_req && !req_d) begin
                ack_seen = 1'b0;
                held     = executed_inst;
                // Ack of the last transfer must have been low before this rise
                if (ack_d) flag_problem("rob_req rose while rob_ack was still high");
                if (exp_q.size() == 0) begin
                    flag_problem("rob_req rose with no issued entry");
                end else begin
                    exp_val  = exp_q.pop_front();
                    exp_num  = num_q.pop_front();
                    exp_name = name_q.pop_front();
                    bad      = 1'b0;
                    if (executed_inst !== exp_val) begin
                        $display("[ERROR] %0s executed_inst expected %h actual %h",
                                 exp_name, exp_val, executed_inst);
                        bad = 1'b1;
                    end
                    if (simple_rob_num !== exp_num) begin
                        $display("[ERROR] %0s simple_rob_num expected %0d actual %0d",
                                 exp_name, exp_num, simple_rob_num);
                        bad = 1'b1;
                    end
                    if (write_en !== exp_val[exec_w-1]) begin
                        $display("[ERROR] %0s write_en expected %b actual %b",
                                 exp_name, exp_val[exec_w-1], write_en);
                        bad = 1'b1;
                    end
                    if (write_en && {write_data, write_addr} !== exp_val[exec_w-2:0]) begin
                        $display("[ERROR] %0s register write expected %h actual %h",
                                 exp_name, exp_val[exec_w-2:0], {write_data, write_addr});
                        bad = 1'b1;
                    end
                    if (bad) fail_count++;
                    else begin
                        $display("[OK] %0s result %h rob %0d", exp_name, exp_val, exp_num);
                        pass_count++;
                    end
                end
            end

            //////////////////////////////
            // Handshake order
            //////////////////////////////

            if (rob_req) begin
                if (rob_ack) ack_seen = 1'b1;
                if (executed_inst !== held)
                    flag_problem("executed_inst changed while rob_req was high");
            end
            if (!rob_req && req_d && !ack_seen) flag_problem("rob_req dropped before rob_ack came");
            if (write_en && wen_d) flag_problem("write_en stayed high for more than one cycle");
            if (write_en && !(rob_req && !req_d)) flag_problem("write_en pulsed outside a new transfer");
            req_d   = rob_req;
            ack_d   = rob_ack;
            wen_d   = write_en;
            pending = exp_q.size();
        end
    end

endmodule

// File: hw/ex_simple.sv
`timescale 1ns/1ns

module ex_simple import simple_fu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // Reservation station slots
    input  logic [entry_w-1:0]    rs_simple_0,
    input  logic [entry_w-1:0]    rs_simple_1,
    input  logic [rob_num_w-1:0]  rs_simple_0_entry_num,
    input  logic [rob_num_w-1:0]  rs_simple_1_entry_num,
    input  logic                  selector,
    output logic                  simple_0_issue,
    output logic                  simple_1_issue,
    // ROB handshake
    output logic [exec_w-1:0]     executed_inst,
    output logic [rob_num_w-1:0]  simple_rob_num,
    output logic                  rob_req,
    input  logic                  rob_ack,
    // Register file write port
    output logic [xlen-1:0]       write_data,
    output logic [reg_addr_w-1:0] write_addr,
    output logic                  write_en
);

    logic                  take;
    logic                  busy;
    logic [aluop_w-1:0]    aluop;
    logic [xlen-1:0]       aluin1;
    logic [xlen-1:0]       aluin2;
    logic [xlen-1:0]       aluout;
    logic [reg_addr_w-1:0] wr_addr;
    logic                  regwrite;
    logic [rob_num_w-1:0]  rob_num;

    // Issue stage, combinational pick
    simple_issue_select u_select (
        .rs_simple_0           (rs_simple_0),
        .rs_simple_1           (rs_simple_1),
        .rs_simple_0_entry_num (rs_simple_0_entry_num),
        .rs_simple_1_entry_num (rs_simple_1_entry_num),
        .selector              (selector),
        .busy                  (busy),
        .simple_0_issue        (simple_0_issue),
        .simple_1_issue        (simple_1_issue),
        .take                  (take),
        .aluop                 (aluop),
        .aluin1                (aluin1),
        .aluin2                (aluin2),
        .wr_addr               (wr_addr),
        .regwrite              (regwrite),
        .rob_num               (rob_num)
    );

    simple_alu u_alu (
        .aluop  (aluop),
        .aluin1 (aluin1),
        .aluin2 (aluin2),
        .aluout (aluout)
    );

    // Result register and ROB handshake
    simple_wb_port u_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .take           (take),
        .aluout         (aluout),
        .wr_addr        (wr_addr),
        .regwrite       (regwrite),
        .rob_num        (rob_num),
        .rob_ack        (rob_ack),
        .busy           (busy),
        .rob_req        (rob_req),
        .executed_inst  (executed_inst),
        .simple_rob_num (simple_rob_num),
        .write_data     (write_data),
        .write_addr     (write_addr),
        .write_en       (write_en)
    );

endmodule

// File: hw/simple_wb_port.sv
`timescale 1ns/1ns

module simple_wb_port import simple_fu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  take,
    input  logic [xlen-1:0]       aluout,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic                  regwrite,
    input  logic [rob_num_w-1:0]  rob_num,
    input  logic                  rob_ack,
    output logic                  busy,
    output logic                  rob_req,
    output logic [exec_w-1:0]     executed_inst,
    output logic [rob_num_w-1:0]  simple_rob_num,
    output logic [xlen-1:0]       write_data,
    output logic [reg_addr_w-1:0] write_addr,
    output logic                  write_en
);

    logic [1:0]            state;
    logic                  wr_pulse;
    logic [xlen-1:0]       result_q;
    logic [reg_addr_w-1:0] addr_q;
    logic                  regwrite_q;
    logic [rob_num_w-1:0]  rob_num_q;

    //////////////////////////////
    // Result capture
    //////////////////////////////

    // Held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (take) begin
            result_q   <= aluout;
            addr_q     <= wr_addr;
            regwrite_q <= regwrite;
            rob_num_q  <= rob_num;
        end
    end

    //////////////////////////////
    // Four-phase handshake FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            wr_pulse <= 1'b0;
        end else begin
            // Register file write only in first request cycle
            wr_pulse <= take & regwrite;
            case (state)
                st_idle: begin
                    if (take) state <= st_req;
                end
                // Req up, wait for ack
                st_req: begin
                    if (rob_ack) state <= st_wait_low;
                end
                // Req down, ack must drop before next issue
                st_wait_low: begin
                    if (!rob_ack) state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign busy    = state != st_idle;
    assign rob_req = state == st_req;

    // Outputs toward ROB and register file
    assign executed_inst  = {regwrite_q, result_q, addr_q};
    assign simple_rob_num = rob_num_q;
    assign write_data     = result_q;
    assign write_addr     = addr_q;
    assign write_en       = wr_pulse;

endmodule

// File: hw/simple_issue_select.sv
`timescale 1ns/1ns

module simple_issue_select import simple_fu_pkg::*; (
    input  logic [entry_w-1:0]    rs_simple_0,
    input  logic [entry_w-1:0]    rs_simple_1,
    input  logic [rob_num_w-1:0]  rs_simple_0_entry_num,
    input  logic [rob_num_w-1:0]  rs_simple_1_entry_num,
    // High when slot 1 holds the newer entry
    input  logic                  selector,
    input  logic                  busy,
    output logic                  simple_0_issue,
    output logic                  simple_1_issue,
    output logic                  take,
    output logic [aluop_w-1:0]    aluop,
    output logic [xlen-1:0]       aluin1,
    output logic [xlen-1:0]       aluin2,
    output logic [reg_addr_w-1:0] wr_addr,
    output logic                  regwrite,
    output logic [rob_num_w-1:0]  rob_num
);

    logic                 ready0;
    logic                 ready1;
    logic [entry_w-1:0]   win_entry;

    //////////////////////////////
    // Readiness and arbitration
    //////////////////////////////

    // Both source operands must be valid
    assign ready0 = rs_simple_0[s1_valid_bit] & rs_simple_0[s2_valid_bit];
    assign ready1 = rs_simple_1[s1_valid_bit] & rs_simple_1[s2_valid_bit];

    // Both ready means the older slot goes first
    // Selector points at the newer one
    assign simple_0_issue = !busy && ready0 && (!ready1 || selector);
    assign simple_1_issue = !busy && ready1 && (!ready0 || !selector);

    assign take = simple_0_issue | simple_1_issue;

    // Winning entry, all zero when idle
    always_comb begin
        win_entry = '0;
        rob_num   = '0;
        if (simple_0_issue) begin
            win_entry = rs_simple_0;
            rob_num   = rs_simple_0_entry_num;
        end else if (simple_1_issue) begin
            win_entry = rs_simple_1;
            rob_num   = rs_simple_1_entry_num;
        end
    end

    // Field unpack
    assign aluop    = win_entry[aluop_lsb +: aluop_w];
    assign aluin1   = win_entry[s1_lsb +: xlen];
    assign aluin2   = win_entry[s2_lsb +: xlen];
    assign wr_addr  = win_entry[rd_lsb +: reg_addr_w];
    assign regwrite = win_entry[regwrite_bit];

endmodule

// File: hw/simple_alu.sv
`timescale 1ns/1ns

module simple_alu import simple_fu_pkg::*; (
    input  logic [aluop_w-1:0] aluop,
    // Source 1 operand, register or pc
    input  logic [xlen-1:0]    aluin1,
    // Source 2 operand, register, immediate or shamt
    input  logic [xlen-1:0]    aluin2,
    output logic [xlen-1:0]    aluout
);

    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;

    //////////////////////////////
    // Shared arithmetic
    //////////////////////////////

    // Only the low five bits count for shifts
    assign shamt = aluin2[4:0];

    assign sum  = aluin1 + aluin2;
    assign diff = aluin1 - aluin2;

    // Compare results for slt and sltu
    assign lt_signed   = $signed(aluin1) < $signed(aluin2);
    assign lt_unsigned = aluin1 < aluin2;

    //////////////////////////////
    // Opcode decode
    //////////////////////////////

    always_comb begin
        case (aluop)
            alu_add: begin
                aluout = sum;
            end
            alu_sub: begin
                aluout = diff;
            end
            alu_and: begin
                aluout = aluin1 & aluin2;
            end
            alu_or: begin
                aluout = aluin1 | aluin2;
            end
            alu_xor: begin
                aluout = aluin1 ^ aluin2;
            end
            // Logical shifts fill with zero
            alu_sll: begin
                aluout = aluin1 << shamt;
            end
            alu_srl: begin
                aluout = aluin1 >> shamt;
            end
            // Arithmetic shift keeps the sign bit
            alu_sra: begin
                aluout = $unsigned($signed(aluin1) >>> shamt);
            end
            // Set-less-than gives 1 or 0
            alu_slt: begin
                aluout = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                aluout = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_pass2: begin
                aluout = aluin2;
            end
            // Unused codes read as zero
            default: begin
                aluout = '0;
            end
        endcase
    end

endmodule

// File: hw/simple_fu_pkg.sv
package simple_fu_pkg;

    //////////////////////////////
    // Word sizes
    //////////////////////////////

    localparam int entry_w    = 81;
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int rob_num_w  = 4;
    localparam int aluop_w    = 5;
    // Regwrite plus result plus destination
    localparam int exec_w     = 1 + xlen + reg_addr_w;

    //////////////////////////////
    // Entry field positions
    //////////////////////////////

    // Layout from bit 80 down to bit 0
    // aluop, memwrite, memread, memtoreg, branch, regwrite, s2, s2 valid, s1, s1 valid, rd
    localparam int rd_lsb       = 0;
    localparam int s1_valid_bit = 5;
    localparam int s1_lsb       = 6;
    localparam int s2_valid_bit = 38;
    localparam int s2_lsb       = 39;
    localparam int regwrite_bit = 71;
    // Bits 72 to 75 hold memory and branch control, not used here
    localparam int aluop_lsb    = 76;

    //////////////////////////////
    // ALU opcodes
    //////////////////////////////

    localparam logic [aluop_w-1:0] alu_add   = 5'd0;
    localparam logic [aluop_w-1:0] alu_sub   = 5'd1;
    localparam logic [aluop_w-1:0] alu_and   = 5'd2;
    localparam logic [aluop_w-1:0] alu_or    = 5'd3;
    localparam logic [aluop_w-1:0] alu_xor   = 5'd4;
    localparam logic [aluop_w-1:0] alu_sll   = 5'd5;
    localparam logic [aluop_w-1:0] alu_srl   = 5'd6;
    localparam logic [aluop_w-1:0] alu_sra   = 5'd7;
    localparam logic [aluop_w-1:0] alu_slt   = 5'd8;
    localparam logic [aluop_w-1:0] alu_sltu  = 5'd9;
    // Source 2 straight through, used for lui
    localparam logic [aluop_w-1:0] alu_pass2 = 5'd10;

    // Writeback FSM state codes
    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_req      = 2'd1;
    localparam logic [1:0] st_wait_low = 2'd2;

endpackage
